// File: all.f
src/exec_pkg.sv
src/exec_alu.sv
src/register_file.sv
src/mul_div_unit.sv
src/mem_access.sv
src/fetch_control.sv
src/execute_core.sv
dv/tb_execute_sva.sv
dv/tb_execute.sv

// File: dv/tb_execute.sv
`timescale 1ns/1ps
`default_nettype none

module tb_execute;
	import exec_pkg::*;

	localparam pc_t start_pc = 31'h0000_0200;
	localparam int max_rows = 96;
	localparam int md_steps = 32;

	typedef struct packed {
		instr_kind_t  kind;
		alu_op_t      op;
		reg_addr_t    rd;
		reg_addr_t    rs1;
		reg_addr_t    rs2;
		logic         use_rs2;
		word_t        imm;
		logic         byte_op;
		branch_cond_t cond;
		word_t        rdata;
		logic [3:0]   delay;
		logic         taken;
		pc_t          exp_pc;
		mem_addr_t    exp_addr;
		word_t        exp_data;
		wmask_t       exp_mask;
	} row_t;

	logic         clk;
	logic         reset;
	logic         iready;
	instr_kind_t  kind;
	alu_op_t      op;
	reg_addr_t    rd;
	reg_addr_t    rs1;
	reg_addr_t    rs2;
	logic         needs_rs2;
	word_t        imm;
	logic         byte_op;
	branch_cond_t cond;
	logic         rdone;
	logic         wdone;
	word_t        rdata;
	pc_t          pc;
	logic         ifetch;
	mem_addr_t    addr;
	word_t        wdata;
	wmask_t       wmask;
	logic         rstrobe;

	row_t   rows [0:max_rows-1];
	string  names [0:max_rows-1];
	int     num_rows = 0;
	int     cycles = 0;
	integer seed;
	word_t  model_regs [0:15]; // entry 7 is the mul/div high word
	pc_t    model_pc;

	execute_core #(
		.reset_pc(start_pc)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.iready(iready),
		.kind(kind),
		.op(op),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.needs_rs2(needs_rs2),
		.imm(imm),
		.byte_op(byte_op),
		.cond(cond),
		.rdone(rdone),
		.wdone(wdone),
		.rdata(rdata),
		.pc(pc),
		.ifetch(ifetch),
		.addr(addr),
		.wdata(wdata),
		.wmask(wmask),
		.rstrobe(rstrobe)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > 60 * num_rows + 100) begin
			$display("timeout: no progress after %0d cycles", cycles);
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end
	end

	function automatic word_t read_reg(input reg_addr_t r);
		return (r == '0) ? '0 : model_regs[r];
	endfunction

	function automatic void write_reg(input reg_addr_t r, input word_t v);
		if (r != '0) model_regs[r] = v;
	endfunction

	function automatic word_t alu_model(input alu_op_t o, input word_t a, input word_t b);
		word_t s;
		s = a + b;
		case (o)
			op_add:   return s;
			op_sub:   return a - b;
			op_xor:   return a ^ b;
			op_or:    return a | b;
			op_and:   return a & b;
			op_sll:   return a << b[4:0];
			op_sra:   return $signed(a) >>> b[4:0];
			op_srl:   return a >> b[4:0];
			op_addb:  return {{24{s[7]}}, s[7:0]};
			op_addbu: return {24'h0, s[7:0]};
			default:  return {16'h0, b[7:0], b[15:8]}; // swap
		endcase
	endfunction

	// runs the model on one instruction and stores it with its expected values
	task automatic add_row(input string name, input instr_kind_t k, input alu_op_t o,
			input reg_addr_t d, input reg_addr_t s1, input reg_addr_t s2, input word_t im,
			input logic bop, input branch_cond_t c, input word_t rword);
		row_t        r;
		logic        use_b;
		logic        taken;
		word_t       a;
		word_t       b;
		word_t       ea;
		word_t       sd;
		logic [63:0] prod;
		use_b = k == kind_mul || k == kind_div || (k == kind_alu && s2 != '0); // rs2 of 0 = imm form
		taken = 1'b0;
		a = read_reg(s1);
		sd = read_reg(s2);
		b = use_b ? sd : im;
		ea = a + im;
		r = '0;
		r.kind = k;
		r.op = o;
		r.rd = d;
		r.rs1 = s1;
		r.rs2 = s2;
		r.use_rs2 = use_b;
		r.imm = im;
		r.byte_op = bop;
		r.cond = c;
		r.rdata = rword;
		r.delay = 4'($unsigned($random(seed)) % 6);
		r.exp_pc = model_pc;
		model_pc = model_pc + 1'b1;
		case (k)
			kind_alu: write_reg(d, alu_model(o, a, b));
			kind_store: begin
				r.exp_addr = ea[31:2];
				r.exp_mask = bop ? 4'b0001 << ea[1:0] : 4'b1111;
				r.exp_data = bop ? {4{sd[7:0]}} : sd;
			end
			kind_load: begin
				r.exp_addr = ea[31:2];
				write_reg(d, bop ? {{24{rword[7]}}, rword[7:0]} : rword);
			end
			kind_mul: begin
				prod = {32'h0, a} * {32'h0, b};
				write_reg(hi_reg, prod[63:32]);
				write_reg(d, prod[31:0]);
			end
			kind_div: begin
				write_reg(hi_reg, (b == 0) ? 0 : a % b);
				write_reg(d, (b == 0) ? 0 : a / b);
			end
			kind_branch: begin
				taken = (c == cond_eqz) ? a == 0 : (c == cond_nez) ? a != 0 :
					(c == cond_gez) ? !a[31] : a[31];
				ea = {r.exp_pc, 1'b0} + im;
				if (taken) model_pc = ea[31:1];
			end
			default: begin // jump
				taken = 1'b1;
				model_pc = ea[31:1];
			end
		endcase
		r.taken = taken;
		rows[num_rows] = r;
		names[num_rows] = name;
		num_rows++;
	endtask

	task automatic alu_row(input string name, input alu_op_t o, input reg_addr_t d,
			input reg_addr_t s1, input reg_addr_t s2, input word_t im);
		add_row(name, kind_alu, o, d, s1, s2, im, 1'b0, cond_eqz, '0);
	endtask

	task automatic mem_row(input string name, input instr_kind_t k, input logic bop,
			input reg_addr_t d, input reg_addr_t s1, input reg_addr_t s2, input word_t im,
			input word_t rword);
		add_row(name, k, op_add, d, s1, s2, im, bop, cond_eqz, rword);
	endtask

	task automatic flow_row(input string name, input instr_kind_t k, input branch_cond_t c,
			input reg_addr_t s1, input word_t im);
		add_row(name, k, op_add, '0, s1, '0, im, 1'b0, c, '0);
	endtask

	// mul or div, then stores of the low word and of register 7
	task automatic muldiv_rows(input string name, input instr_kind_t k, input reg_addr_t d,
			input reg_addr_t s1, input reg_addr_t s2);
		add_row(name, k, op_add, d, s1, s2, '0, 1'b0, cond_eqz, '0);
		mem_row({name, "_lo"}, kind_store, 1'b0, '0, '0, d, 32'h60, '0);
		mem_row({name, "_hi"}, kind_store, 1'b0, '0, '0, hi_reg, 32'h64, '0);
	endtask

	task automatic build_table();
		alu_op_t o;
		alu_row("li_r1", op_add, 4'd1, 4'd0, 4'd0, 32'h8765_4321);
		alu_row("li_r2", op_add, 4'd2, 4'd0, 4'd0, 32'h0000_0013);
		for (int j = 0; j <= op_swap; j++) begin
			o = alu_op_t'(j);
			alu_row({"alu_", o.name()}, o, 4'd3, 4'd1, 4'd2, '0);
			mem_row({"st_", o.name()}, kind_store, 1'b0, '0, '0, 4'd3, 32'h40, '0);
		end
		alu_row("addb_imm", op_addb, 4'd3, 4'd1, 4'd0, 32'h5f); // low byte carries to 0x80
		mem_row("st_addb_imm", kind_store, 1'b0, '0, '0, 4'd3, 32'h44, '0);
		alu_row("addbu_imm", op_addbu, 4'd3, 4'd1, 4'd0, 32'h5f);
		mem_row("st_addbu_imm", kind_store, 1'b0, '0, '0, 4'd3, 32'h44, '0);
		alu_row("chain_a", op_add, 4'd4, 4'd1, 4'd0, 32'h5);
		alu_row("chain_b", op_xor, 4'd5, 4'd4, 4'd2, '0);
		alu_row("chain_c", op_sub, 4'd6, 4'd5, 4'd4, '0);
		mem_row("st_chain", kind_store, 1'b0, '0, '0, 4'd6, 32'h48, '0);
		for (int j = 0; j < 4; j++) begin
			mem_row($sformatf("sb_lane%0d", j), kind_store, 1'b1, '0, '0, 4'd1, 32'h80 + j, '0);
		end
		mem_row("sw_addr", kind_store, 1'b0, '0, 4'd2, 4'd1, 32'h1001, '0);
		mem_row("lw", kind_load, 1'b0, 4'd8, 4'd0, '0, 32'h200, 32'hdead_beef);
		mem_row("st_lw", kind_store, 1'b0, '0, '0, 4'd8, 32'h4c, '0);
		mem_row("lb_neg", kind_load, 1'b1, 4'd9, 4'd0, '0, 32'h201, 32'h1234_56a7);
		alu_row("use_lb", op_add, 4'd10, 4'd9, 4'd0, 32'h1);
		mem_row("st_use_lb", kind_store, 1'b0, '0, '0, 4'd10, 32'h50, '0);
		mem_row("lb_pos", kind_load, 1'b1, 4'd11, 4'd0, '0, 32'h203, 32'hffff_ff42);
		mem_row("st_lb_pos", kind_store, 1'b0, '0, '0, 4'd11, 32'h54, '0);
		muldiv_rows("mul", kind_mul, 4'd12, 4'd1, 4'd2);
		muldiv_rows("mul_big", kind_mul, 4'd12, 4'd1, 4'd1);
		muldiv_rows("div", kind_div, 4'd13, 4'd1, 4'd2);
		muldiv_rows("div_zero", kind_div, 4'd13, 4'd1, 4'd0);
		alu_row("li_r7", op_add, hi_reg, 4'd0, 4'd0, 32'h5a5a_0001);
		mem_row("st_r7_bypass", kind_store, 1'b0, '0, '0, hi_reg, 32'h68, '0);
		mem_row("st_r7", kind_store, 1'b0, '0, '0, hi_reg, 32'h6c, '0);
		alu_row("li_r14", op_add, 4'd14, 4'd0, 4'd0, '0);
		flow_row("beqz_taken", kind_branch, cond_eqz, 4'd14, 32'h10);
		flow_row("beqz_not", kind_branch, cond_eqz, 4'd1, 32'h10);
		flow_row("bnez_taken", kind_branch, cond_nez, 4'd1, 32'hffff_fff0);
		flow_row("bnez_not", kind_branch, cond_nez, 4'd0, 32'h10);
		flow_row("bgez_taken", kind_branch, cond_gez, 4'd2, 32'h22);
		flow_row("bgez_not", kind_branch, cond_gez, 4'd1, 32'h22);
		flow_row("bltz_taken", kind_branch, cond_ltz, 4'd1, 32'h6);
		flow_row("bltz_not", kind_branch, cond_ltz, 4'd2, 32'h6);
		flow_row("jump", kind_jump, cond_eqz, 4'd2, 32'h0401);
		alu_row("after_jump", op_add, 4'd15, 4'd0, 4'd0, 32'h1);
	endtask

	task automatic check_value(input string name, input string what, input word_t expected,
			input word_t actual);
		assert (actual === expected) else begin
			$display("[FAIL] %s %s: expected 0x%h, actual 0x%h", name, what, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// called on a falling edge
	task automatic wait_ifetch();
		while (ifetch !== 1'b1) @(negedge clk);
	endtask

	task automatic apply_row(input int i);
		row_t r;
		r = rows[i];
		wait_ifetch();
		check_value(names[i], "pc", r.exp_pc, pc);
		kind = r.kind;
		op = r.op;
		rd = r.rd;
		rs1 = r.rs1;
		rs2 = r.rs2;
		needs_rs2 = r.use_rs2;
		imm = r.imm;
		byte_op = r.byte_op;
		cond = r.cond;
		iready = 1'b1;
		@(negedge clk);
		iready = 1'b0;
		check_value(names[i], "ifetch", r.kind == kind_alu || (r.kind == kind_branch && !r.taken),
			ifetch);
		if (r.taken) begin
			@(negedge clk);
			check_value(names[i], "ifetch after stall", 1, ifetch);
		end
		if (r.kind == kind_mul || r.kind == kind_div) begin
			repeat (md_steps) begin // busy steps, then the done cycle
				@(negedge clk);
				check_value(names[i], "ifetch while busy", 0, ifetch);
			end
			@(negedge clk);
			check_value(names[i], "ifetch after done", 1, ifetch);
		end
		if (r.kind == kind_store || r.kind == kind_load) begin
			check_value(names[i], "addr", r.exp_addr, addr);
			if (r.kind == kind_store) begin
				check_value(names[i], "wdata", r.exp_data, wdata);
				check_value(names[i], "wmask", r.exp_mask, wmask);
			end else begin
				check_value(names[i], "rstrobe", 1, rstrobe);
			end
			repeat (r.delay) @(negedge clk);
			rdata = r.rdata;
			rdone = r.kind == kind_load;
			wdone = r.kind == kind_store;
			@(negedge clk);
			rdone = 1'b0;
			wdone = 1'b0;
			check_value(names[i], "ifetch after completion", 1, ifetch);
			check_value(names[i], "strobes after completion", 0, {rstrobe, wmask});
		end
	endtask

	initial begin
		seed = 32'h1c23_f109;
		reset = 1'b1;
		iready = 1'b0;
		kind = kind_alu;
		op = op_add;
		rd = '0;
		rs1 = '0;
		rs2 = '0;
		needs_rs2 = 1'b0;
		imm = '0;
		byte_op = 1'b0;
		cond = cond_eqz;
		rdone = 1'b0;
		wdone = 1'b0;
		rdata = '0;
		model_pc = start_pc;
		build_table();
		repeat (8) @(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < num_rows; i++) apply_row(i);
		wait_ifetch();
		check_value("final", "pc", model_pc, pc);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/tb_execute_sva.sv
`timescale 1ns/1ps
`default_nettype none

module tb_execute_sva (
	input logic             clk,
	input logic             reset,
	input logic             rstrobe,
	input exec_pkg::wmask_t wmask,
	input logic             ifetch,
	input logic             md_busy
);

	a_one_access: assert property (@(posedge clk) disable iff (reset)
		!(rstrobe && wmask != '0))
		else $error("rstrobe and a nonzero wmask are active in the same cycle");

	// none, one byte lane or the whole word
	a_mask_shape: assert property (@(posedge clk) disable iff (reset)
		wmask == '0 || $onehot(wmask) || wmask == '1)
		else $error("wmask is neither zero, one-hot nor all ones");

	a_no_fetch_busy: assert property (@(posedge clk) disable iff (reset)
		md_busy |-> !ifetch)
		else $error("ifetch is high while the multiply/divide unit is busy");

	a_fetch_after_reset: assert property (@(posedge clk) $fell(reset) |-> ifetch)
		else $error("ifetch is low in the first cycle after reset");

endmodule

bind mem_access tb_execute_sva u_mem_sva (
	.clk(clk),
	.reset(reset),
	.rstrobe(rstrobe),
	.wmask(wmask),
	.ifetch(1'b1),
	.md_busy(1'b0)
);

bind fetch_control tb_execute_sva u_fetch_sva (
	.clk(clk),
	.reset(reset),
	.rstrobe(1'b0),
	.wmask('0),
	.ifetch(ifetch),
	.md_busy(md_busy)
);

`default_nettype wire

// File: src/execute_core.sv
`timescale 1ns/1ps
`default_nettype none

module execute_core #(
	parameter exec_pkg::pc_t reset_pc = '0
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   iready,
	input  exec_pkg::instr_kind_t  kind,
	input  exec_pkg::alu_op_t      op,
	input  exec_pkg::reg_addr_t    rd,
	input  exec_pkg::reg_addr_t    rs1,
	input  exec_pkg::reg_addr_t    rs2,
	input  logic                   needs_rs2,
	input  exec_pkg::word_t        imm,
	input  logic                   byte_op,
	input  exec_pkg::branch_cond_t cond,
	input  logic                   rdone,
	input  logic                   wdone,
	input  exec_pkg::word_t        rdata,
	output exec_pkg::pc_t          pc,
	output logic                   ifetch,
	output exec_pkg::mem_addr_t    addr,
	output exec_pkg::word_t        wdata,
	output exec_pkg::wmask_t       wmask,
	output logic                   rstrobe
);
	import exec_pkg::*;

	logic      accept;
	word_t     rs1_data;
	word_t     rs2_data;
	word_t     alu_result;
	logic      md_busy;
	logic      md_done;
	word_t     md_lo;
	reg_addr_t md_rd;
	word_t     hi_data;
	logic      mem_busy;
	logic      load_done;
	word_t     load_data;
	reg_addr_t mem_rd;
	logic      hi_write;
	word_t     wb_data;

	fetch_control #(
		.reset_pc(reset_pc)
	) u_fetch (
		.clk(clk),
		.reset(reset),
		.iready(iready),
		.kind(kind),
		.cond(cond),
		.rs1_data(rs1_data),
		.alu_result(alu_result),
		.md_busy(md_busy),
		.md_done(md_done),
		.mem_busy(mem_busy),
		.accept(accept),
		.ifetch(ifetch),
		.pc(pc)
	);

	register_file u_regs (
		.clk(clk),
		.reset(reset),
		.accept(accept),
		.kind(kind),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.alu_result(alu_result),
		.load_done(load_done),
		.load_data(load_data),
		.md_done(md_done),
		.md_lo(md_lo),
		.md_rd(md_rd),
		.hi_data(hi_data),
		.mem_rd(mem_rd),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.hi_write(hi_write),
		.wb_data(wb_data)
	);

	exec_alu u_alu (
		.op(op),
		.kind(kind),
		.needs_rs2(needs_rs2),
		.imm(imm),
		.pc(pc),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.alu_result(alu_result)
	);

	mul_div_unit u_muldiv (
		.clk(clk),
		.reset(reset),
		.accept(accept),
		.kind(kind),
		.rd(rd),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.hi_write(hi_write),
		.wb_data(wb_data),
		.md_busy(md_busy),
		.md_done(md_done),
		.md_lo(md_lo),
		.md_rd(md_rd),
		.hi_data(hi_data)
	);

	mem_access u_mem (
		.clk(clk),
		.reset(reset),
		.accept(accept),
		.kind(kind),
		.byte_op(byte_op),
		.rd(rd),
		.alu_result(alu_result),
		.rs2_data(rs2_data),
		.rdone(rdone),
		.wdone(wdone),
		.rdata(rdata),
		.addr(addr),
		.wdata(wdata),
		.wmask(wmask),
		.rstrobe(rstrobe),
		.mem_busy(mem_busy),
		.load_done(load_done),
		.load_data(load_data),
		.mem_rd(mem_rd)
	);

endmodule

`default_nettype wire

// File: src/fetch_control.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_control #(
	parameter exec_pkg::pc_t reset_pc = '0
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   iready,
	input  exec_pkg::instr_kind_t  kind,
	input  exec_pkg::branch_cond_t cond,
	input  exec_pkg::word_t        rs1_data,
	input  exec_pkg::word_t        alu_result,
	input  logic                   md_busy,
	input  logic                   md_done,
	input  logic                   mem_busy,
	output logic                   accept,
	output logic                   ifetch,
	output exec_pkg::pc_t          pc
);
	import exec_pkg::*;

	logic branch_stall;
	logic cond_met;
	logic taken;

	always_comb begin
		case (cond)
			cond_eqz: cond_met = rs1_data == '0;
			cond_nez: cond_met = rs1_data != '0;
			cond_gez: cond_met = !rs1_data[word_width-1];
			default:  cond_met = rs1_data[word_width-1]; // ltz
		endcase
	end

	assign taken = accept && (kind == kind_jump || (kind == kind_branch && cond_met));

	// md_done cycle is the write-back slot of the result
	assign ifetch = !(branch_stall || mem_busy || md_busy || md_done);
	assign accept = iready && ifetch;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= reset_pc;
			branch_stall <= 1'b0;
		end else begin
			branch_stall <= taken;
			if (taken) begin
				pc <= alu_result[word_width-1:1];
			end else if (accept) begin
				pc <= pc + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/mem_access.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  accept,
	input  exec_pkg::instr_kind_t kind,
	input  logic                  byte_op,
	input  exec_pkg::reg_addr_t   rd,
	input  exec_pkg::word_t       alu_result,
	input  exec_pkg::word_t       rs2_data,
	input  logic                  rdone,
	input  logic                  wdone,
	input  exec_pkg::word_t       rdata,
	output exec_pkg::mem_addr_t   addr,
	output exec_pkg::word_t       wdata,
	output exec_pkg::wmask_t      wmask,
	output logic                  rstrobe,
	output logic                  mem_busy,
	output logic                  load_done,
	output exec_pkg::word_t       load_data,
	output exec_pkg::reg_addr_t   mem_rd
);
	import exec_pkg::*;

	mem_state_t state;
	wmask_t     lanes;
	logic       load_byte;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mem_idle;
		end else begin
			case (state)
				mem_idle: begin
					if (accept && kind == kind_load) begin
						state <= mem_load;
					end else if (accept && kind == kind_store) begin
						state <= mem_store;
					end
				end
				mem_load:  if (rdone) state <= mem_idle;
				mem_store: if (wdone) state <= mem_idle;
				default:   state <= mem_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept && (kind == kind_load || kind == kind_store)) begin
			addr <= alu_result[word_width-1:2];
			wdata <= byte_op ? {(word_width/8){rs2_data[7:0]}} : rs2_data;
			lanes <= byte_op ? wmask_t'(1'b1) << alu_result[1:0] : '1;
			load_byte <= byte_op;
			mem_rd <= rd;
		end
	end

	assign wmask = (state == mem_store) ? lanes : '0;
	assign rstrobe = state == mem_load;
	assign mem_busy = state != mem_idle;
	assign load_done = rstrobe && rdone;
	assign load_data = load_byte ? {{(word_width-8){rdata[7]}}, rdata[7:0]} : rdata;

endmodule

`default_nettype wire

// File: src/mul_div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_div_unit (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  accept,
	input  exec_pkg::instr_kind_t kind,
	input  exec_pkg::reg_addr_t   rd,
	input  exec_pkg::word_t       rs1_data,
	input  exec_pkg::word_t       rs2_data,
	input  logic                  hi_write,
	input  exec_pkg::word_t       wb_data,
	output logic                  md_busy,
	output logic                  md_done,
	output exec_pkg::word_t       md_lo,
	output exec_pkg::reg_addr_t   md_rd,
	output exec_pkg::word_t       hi_data
);
	import exec_pkg::*;

	logic                    start;
	logic                    is_div;
	shift_t                  step;
	word_t                   a;
	word_t                   b;
	logic [2*word_width-1:0] acc;   // {hi, lo}
	logic [word_width:0]     trial; // remainder shifted in
	logic [word_width:0]     diff;

	assign start = accept && (kind == kind_mul || kind == kind_div);
	assign trial = {acc[2*word_width-1:word_width], a[step]};
	assign diff = trial - {1'b0, b};

	always_ff @(posedge clk) begin
		if (reset) begin
			md_busy <= 1'b0;
			md_done <= 1'b0;
			step <= '0;
		end else begin
			md_done <= md_busy && step == '0;
			if (start) begin
				md_busy <= 1'b1;
				step <= '1; // msb first
			end else if (md_busy) begin
				md_busy <= step != '0;
				step <= step - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			is_div <= kind == kind_div;
			a <= rs1_data;
			b <= rs2_data;
			md_rd <= rd;
			acc <= '0;
		end else if (md_busy) begin
			if (!is_div) begin
				acc <= {acc[2*word_width-2:0], 1'b0} + (a[step] ? {{word_width{1'b0}}, b} : '0);
			end else if (b == '0) begin
				acc <= '0; // divide by zero
			end else if (!diff[word_width]) begin
				acc <= {diff[word_width-1:0], acc[word_width-2:0], 1'b1};
			end else begin
				acc <= {trial[word_width-1:0], acc[word_width-2:0], 1'b0}; // restore
			end
		end else if (hi_write) begin
			acc[2*word_width-1:word_width] <= wb_data;
		end
	end

	assign hi_data = acc[2*word_width-1:word_width];
	assign md_lo = acc[word_width-1:0];

endmodule

`default_nettype wire

// File: src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  accept,
	input  exec_pkg::instr_kind_t kind,
	input  exec_pkg::reg_addr_t   rd,
	input  exec_pkg::reg_addr_t   rs1,
	input  exec_pkg::reg_addr_t   rs2,
	input  exec_pkg::word_t       alu_result,
	input  logic                  load_done,
	input  exec_pkg::word_t       load_data,
	input  logic                  md_done,
	input  exec_pkg::word_t       md_lo,
	input  exec_pkg::reg_addr_t   md_rd,
	input  exec_pkg::word_t       hi_data,
	input  exec_pkg::reg_addr_t   mem_rd,
	output exec_pkg::word_t       rs1_data,
	output exec_pkg::word_t       rs2_data,
	output logic                  hi_write,
	output exec_pkg::word_t       wb_data
);
	import exec_pkg::*;

	word_t     regs [1:15]; // slot 7 never written
	logic      wb_valid;
	reg_addr_t wb_addr;

	function automatic word_t read_port(input reg_addr_t a);
		word_t v;
		if (wb_valid && wb_addr == a && a != '0) begin
			v = wb_data; // bypass pending write-back
		end else if (a == '0) begin
			v = '0;
		end else if (a == hi_reg) begin
			v = hi_data;
		end else begin
			v = regs[a];
		end
		return v;
	endfunction

	always_comb begin
		rs1_data = read_port(rs1);
		rs2_data = read_port(rs2);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= load_done || md_done || (accept && kind == kind_alu);
		end
	end

	always_ff @(posedge clk) begin
		if (load_done) begin
			wb_addr <= mem_rd;
			wb_data <= load_data;
		end else if (md_done) begin
			wb_addr <= md_rd;
			wb_data <= md_lo; // product low or quotient
		end else if (accept) begin
			wb_addr <= rd;
			wb_data <= alu_result;
		end
	end

	always_ff @(posedge clk) begin
		if (wb_valid && wb_addr != '0 && wb_addr != hi_reg) begin
			regs[wb_addr] <= wb_data;
		end
	end

	assign hi_write = wb_valid && wb_addr == hi_reg;

endmodule

`default_nettype wire

// File: src/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
	input  exec_pkg::alu_op_t     op,
	input  exec_pkg::instr_kind_t kind,
	input  logic                  needs_rs2,
	input  exec_pkg::word_t       imm,
	input  exec_pkg::pc_t         pc,
	input  exec_pkg::word_t       rs1_data,
	input  exec_pkg::word_t       rs2_data,
	output exec_pkg::word_t       alu_result
);
	import exec_pkg::*;

	word_t  a;
	word_t  b;
	word_t  sum;
	word_t  op_result;
	shift_t sh;
	logic   left;
	logic   fill;
	word_t  stage [0:5];

	function automatic word_t reverse(input word_t v);
		word_t r;
		for (int i = 0; i < word_width; i++) begin
			r[i] = v[word_width-1-i];
		end
		return r;
	endfunction

	assign a = (kind == kind_branch) ? {pc, 1'b0} : rs1_data; // pc relative
	assign b = needs_rs2 ? rs2_data : imm;
	assign sum = a + b;
	assign sh = b[$bits(shift_t)-1:0];

	// left shift runs the right shifter on the bit-reversed word
	assign left = op == op_sll;
	assign fill = op == op_sra && a[word_width-1];
	assign stage[0] = left ? reverse(a) : a;
	for (genvar i = 0; i < 5; i++) begin : g_shift
		assign stage[i+1] = sh[i] ? {{(2**i){fill}}, stage[i][word_width-1:2**i]} : stage[i];
	end

	always_comb begin
		case (op)
			op_add:   op_result = sum;
			op_sub:   op_result = a - b;
			op_xor:   op_result = a ^ b;
			op_or:    op_result = a | b;
			op_and:   op_result = a & b;
			op_sll:   op_result = reverse(stage[5]);
			op_sra,
			op_srl:   op_result = stage[5];
			op_addb:  op_result = {{(word_width-8){sum[7]}}, sum[7:0]};
			op_addbu: op_result = {{(word_width-8){1'b0}}, sum[7:0]};
			op_swap:  op_result = {{(word_width-16){1'b0}}, b[7:0], b[15:8]};
			default:  op_result = sum;
		endcase
	end

	// targets and memory addresses always take the sum
	assign alu_result = (kind == kind_alu) ? op_result : sum;

endmodule

`default_nettype wire

// File: src/exec_pkg.sv
`default_nettype none

package exec_pkg;

	localparam int word_width = 32;

	typedef logic [word_width-1:0]   word_t;
	typedef logic [3:0]              reg_addr_t;
	typedef logic [word_width-1:1]   pc_t;       // halfword units
	typedef logic [word_width-1:2]   mem_addr_t; // word units
	typedef logic [word_width/8-1:0] wmask_t;
	typedef logic [4:0]              shift_t;

	typedef enum logic [3:0] {
		op_add   = 4'd0,
		op_sub   = 4'd1,
		op_xor   = 4'd2,
		op_or    = 4'd3,
		op_and   = 4'd4,
		op_sll   = 4'd5,
		op_sra   = 4'd6,
		op_srl   = 4'd7,
		op_addb  = 4'd8,
		op_addbu = 4'd9,
		op_swap  = 4'd10
	} alu_op_t;

	typedef enum logic [2:0] {
		kind_alu    = 3'd0,
		kind_load   = 3'd1,
		kind_store  = 3'd2,
		kind_mul    = 3'd3,
		kind_div    = 3'd4,
		kind_branch = 3'd5,
		kind_jump   = 3'd6
	} instr_kind_t;

	typedef enum logic [1:0] {
		cond_eqz = 2'd0,
		cond_nez = 2'd1,
		cond_gez = 2'd2,
		cond_ltz = 2'd3
	} branch_cond_t;

	typedef enum logic [1:0] {
		mem_idle  = 2'd0,
		mem_load  = 2'd1,
		mem_store = 2'd2
	} mem_state_t;

	localparam reg_addr_t hi_reg = 4'd7; // mul/div high word

endpackage

`default_nettype wire
